/* design/dm_macros.svh */
`ifndef DM_MACROS_SVH
`define DM_MACROS_SVH

// matrix is square, same count for rows and columns
`define DM_ROWS 8

// clk cycles per row advance
// kept short for simulation, a board build wants clk / 1 kHz
`define DM_TICK_DIV 16

`endif

/* design/dot_matrix_pkg.sv */
`include "dm_macros.svh"

package dot_matrix_pkg;

    typedef logic [$clog2(`DM_ROWS)-1:0] row_idx_t;
    typedef logic [2:0]                  pattern_sel_t;
    typedef logic [`DM_ROWS-1:0]         col_bits_t;    // 1 = led lit, also the row drive
    typedef logic [1:0]                  color_mask_t;

    // colour mask bit positions
    localparam int COLOR_RED   = 0;
    localparam int COLOR_GREEN = 1;

    // pattern numbers
    localparam pattern_sel_t PAT_DARK    = 3'd0;
    localparam pattern_sel_t PAT_GROW1   = 3'd1;
    localparam pattern_sel_t PAT_GROW2   = 3'd2;
    localparam pattern_sel_t PAT_GROW3   = 3'd3;
    localparam pattern_sel_t PAT_GROW4   = 3'd4;
    localparam pattern_sel_t PAT_FULL    = 3'd5;
    localparam pattern_sel_t PAT_CHECKER = 3'd6;
    localparam pattern_sel_t PAT_BORDER  = 3'd7;

endpackage

/* design/reg_map_pkg.sv */
package reg_map_pkg;

    // host register address
    typedef logic [1:0] reg_addr_t;

    // pattern number, low 3 bits of the write data
    localparam reg_addr_t REG_PATTERN = 2'd0;

    // colour enables, bit 0 red and bit 1 green
    localparam reg_addr_t REG_COLOR   = 2'd1;

    // blank flag, bit 0
    localparam reg_addr_t REG_BLANK   = 2'd2;

    // address 3 decodes to nothing

endpackage

/* design/scan_tick_gen.sv */
`timescale 1ns/10ps
`include "dm_macros.svh"

module scan_tick_gen #(
    parameter int TICK_DIV = `DM_TICK_DIV
) (
    input  logic clk,
    input  logic rst,
    output logic row_tick
);

    // one bit minimum so a divider of 1 still builds
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (wrap)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // registered strobe, one clk wide per period
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_tick <= 1'b0;
        else
            row_tick <= wrap;
    end

endmodule

/* design/matrix_config_regs.sv */
`timescale 1ns/10ps

module matrix_config_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  reg_map_pkg::reg_addr_t       wr_addr,
    input  logic [7:0]                   wr_data,
    output dot_matrix_pkg::pattern_sel_t pattern_sel,
    output dot_matrix_pkg::color_mask_t  color_mask,
    output logic                         blank
);

    import reg_map_pkg::*;
    import dot_matrix_pkg::*;

    localparam int PAT_W  = $bits(pattern_sel_t);
    localparam int MASK_W = $bits(color_mask_t);

    // each register keeps only its low bits of the write data
    pattern_sel_t wr_pattern;
    color_mask_t  wr_mask;

    assign wr_pattern = wr_data[PAT_W-1:0];
    assign wr_mask    = wr_data[MASK_W-1:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pattern_sel <= PAT_DARK;
            color_mask  <= '0;
            blank       <= 1'b0;
        end
        else if (wr_en)
        begin
            case (wr_addr)
                REG_PATTERN:
                begin
                    pattern_sel <= wr_pattern;
                end
                REG_COLOR:
                begin
                    color_mask <= wr_mask;
                end
                REG_BLANK:
                begin
                    blank <= wr_data[0];
                end
                default:
                begin
                    // unused address, write dropped
                end
            endcase
        end
    end

endmodule

/* design/glyph_rom.sv */
`timescale 1ns/10ps

module glyph_rom (
    input  dot_matrix_pkg::pattern_sel_t pattern,
    input  dot_matrix_pkg::row_idx_t     row_idx,
    output dot_matrix_pkg::col_bits_t    col_bits
);

    import dot_matrix_pkg::*;

    always_comb
    begin
        col_bits = '0;  // dark unless a row below says otherwise
        case (pattern)
            PAT_GROW1:
            begin
                case (row_idx)
                    3'd2, 3'd5: col_bits = 8'h18;
                    3'd3, 3'd4: col_bits = 8'h3C;
                    default:    col_bits = '0;
                endcase
            end
            PAT_GROW2:
            begin
                case (row_idx)
                    3'd2, 3'd5: col_bits = 8'h38;
                    3'd3, 3'd4: col_bits = 8'h7C;
                    default:    col_bits = '0;
                endcase
            end
            PAT_GROW3:
            begin
                case (row_idx)
                    3'd2, 3'd5: col_bits = 8'h3C;
                    3'd3, 3'd4: col_bits = 8'h7E;
                    default:    col_bits = '0;
                endcase
            end
            PAT_GROW4:
            begin
                case (row_idx)
                    3'd1, 3'd6:             col_bits = 8'h3C;
                    3'd2, 3'd3, 3'd4, 3'd5: col_bits = 8'h7E;
                    default:                col_bits = '0;
                endcase
            end
            PAT_FULL:
            begin
                col_bits = '1;
            end
            PAT_CHECKER:
            begin
                // alternate phase every row
                if (row_idx[0])
                    col_bits = 8'h55;
                else
                    col_bits = 8'hAA;
            end
            PAT_BORDER:
            begin
                case (row_idx)
                    3'd0, 3'd7: col_bits = 8'hFF;   // top and bottom edge
                    default:    col_bits = 8'h81;   // side columns only
                endcase
            end
            default:
            begin
                col_bits = '0;  // PAT_DARK
            end
        endcase
    end

endmodule

/* design/matrix_row_scanner.sv */
`timescale 1ns/10ps
`include "dm_macros.svh"

module matrix_row_scanner (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         row_tick,
    input  dot_matrix_pkg::pattern_sel_t pattern_sel,
    input  dot_matrix_pkg::color_mask_t  color_mask,
    input  logic                         blank,
    output dot_matrix_pkg::col_bits_t    row,
    output dot_matrix_pkg::col_bits_t    colr,
    output dot_matrix_pkg::col_bits_t    colg
);

    import dot_matrix_pkg::*;

    localparam row_idx_t ROW_LAST = row_idx_t'(`DM_ROWS - 1);

    row_idx_t     row_cnt;
    row_idx_t     next_idx;
    logic         frame_start;

    pattern_sel_t frm_pattern;
    color_mask_t  frm_mask;
    logic         frm_blank;

    pattern_sel_t cur_pattern;
    color_mask_t  cur_mask;
    logic         cur_blank;

    col_bits_t    glyph_bits;
    logic         red_on;
    logic         green_on;

    assign next_idx    = (row_cnt == ROW_LAST) ? '0 : row_cnt + row_idx_t'(1);
    assign frame_start = (next_idx == '0);

    // row 0 takes the live settings, the rest of the frame the latched copy
    assign cur_pattern = frame_start ? pattern_sel : frm_pattern;
    assign cur_mask    = frame_start ? color_mask  : frm_mask;
    assign cur_blank   = frame_start ? blank       : frm_blank;

    assign red_on   = cur_mask[COLOR_RED]   & ~cur_blank;
    assign green_on = cur_mask[COLOR_GREEN] & ~cur_blank;

    glyph_rom u_glyph_rom (
        .pattern  (cur_pattern),
        .row_idx  (next_idx),
        .col_bits (glyph_bits)
    );

    // starts on the last row so the first tick shows row 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_cnt <= ROW_LAST;
        else if (row_tick)
            row_cnt <= next_idx;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frm_pattern <= PAT_DARK;
            frm_mask    <= '0;
            frm_blank   <= 1'b0;
        end
        else if (row_tick && frame_start)
        begin
            frm_pattern <= pattern_sel;
            frm_mask    <= color_mask;
            frm_blank   <= blank;
        end
    end

    // row and columns leave on the same edge from the same index
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;     // nothing driven
            colr <= '0;
            colg <= '0;
        end
        else if (row_tick)
        begin
            row  <= ~(col_bits_t'(1) << next_idx);  // active low
            colr <= red_on   ? glyph_bits : '0;
            colg <= green_on ? glyph_bits : '0;
        end
    end

endmodule

/* design/matrix_display_top.sv */
`timescale 1ns/10ps
`include "dm_macros.svh"

module matrix_display_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  reg_map_pkg::reg_addr_t    wr_addr,
    input  logic [7:0]                wr_data,
    output dot_matrix_pkg::col_bits_t row,
    output dot_matrix_pkg::col_bits_t colr,
    output dot_matrix_pkg::col_bits_t colg
);

    import dot_matrix_pkg::*;

    logic         row_tick;
    pattern_sel_t pattern_sel;
    color_mask_t  color_mask;
    logic         blank;

    // row rate enable
    scan_tick_gen #(
        .TICK_DIV (`DM_TICK_DIV)
    ) u_tick_gen (
        .clk      (clk),
        .rst      (rst),
        .row_tick (row_tick)
    );

    // host side settings
    matrix_config_regs u_config_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .pattern_sel (pattern_sel),
        .color_mask  (color_mask),
        .blank       (blank)
    );

    matrix_row_scanner u_row_scanner (
        .clk         (clk),
        .rst         (rst),
        .row_tick    (row_tick),
        .pattern_sel (pattern_sel),
        .color_mask  (color_mask),
        .blank       (blank),
        .row         (row),
        .colr        (colr),
        .colg        (colg)
    );

endmodule

/* verification/matrix_tb_model.svh */
`ifndef MATRIX_TB_MODEL_SVH
`define MATRIX_TB_MODEL_SVH

// expected column bits for one row of a pattern
function automatic logic [7:0] ref_glyph(input logic [2:0] pattern, input logic [2:0] r);
    logic [7:0] bits;
    logic       outer_row;
    logic       inner_row;
    bits      = 8'h00;
    outer_row = (r == 3'd2) || (r == 3'd5);
    inner_row = (r == 3'd3) || (r == 3'd4);
    case (pattern)
        3'd1: bits = outer_row ? 8'h18 : (inner_row ? 8'h3C : 8'h00);
        3'd2: bits = outer_row ? 8'h38 : (inner_row ? 8'h7C : 8'h00);
        3'd3: bits = outer_row ? 8'h3C : (inner_row ? 8'h7E : 8'h00);
        3'd4:
        begin
            if (r == 3'd1 || r == 3'd6)
                bits = 8'h3C;
            else if (outer_row || inner_row)
                bits = 8'h7E;
        end
        3'd5: bits = 8'hFF;
        3'd6: bits = (r % 2 == 0) ? 8'hAA : 8'h55;
        3'd7: bits = (r == 3'd0 || r == 3'd7) ? 8'hFF : 8'h81;
        default: bits = 8'h00;
    endcase
    return bits;
endfunction

// {colg, colr} for the given settings and row
function automatic logic [15:0] expected_cols(input logic [2:0] pattern, input logic [1:0] mask,
                                              input logic blank, input logic [2:0] r);
    logic [7:0] glyph;
    logic [7:0] red;
    logic [7:0] green;
    glyph = ref_glyph(pattern, r);
    red   = (mask[0] && !blank) ? glyph : 8'h00;
    green = (mask[1] && !blank) ? glyph : 8'h00;
    return {green, red};
endfunction

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
        return (s >> 1) ^ 32'h8020_0003;
    else
        return s >> 1;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

`endif

/* verification/matrix_display_tb.sv */
`timescale 1ns/10ps
`include "dm_macros.svh"

module matrix_display_tb;

    import reg_map_pkg::*;

    // settling takes 16 rows and reaching row 0 up to 8 more before 8 are checked
    localparam int CHECKED_FRAMES = 29;
    localparam int ROWS_PER_FRAME = 40;
    localparam int CYCLE_LIMIT    = CHECKED_FRAMES * ROWS_PER_FRAME * `DM_TICK_DIV + 2000;

    logic       clk;
    logic       rst;
    logic       wr_en;
    logic [1:0] wr_addr;
    logic [7:0] wr_data;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    int          errors;
    int          checks;
    int          cycles;
    int          rows_seen;
    int          rows_left;    // rows still to compare in the armed frame
    logic [7:0]  prev_row;
    int          prev_idx;
    logic [2:0]  exp_pattern;
    logic [1:0]  exp_mask;
    logic        exp_blank;
    logic [31:0] lfsr_state;

    `include "matrix_tb_model.svh"

    matrix_display_top DUT (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // row and columns sampled mid-cycle
    always @(negedge clk)
    begin
        int         idx;
        logic [15:0] exp;
        if (row !== prev_row)
        begin
            prev_row = row;
            rows_seen++;
            if ($countones(~row) != 1)
            begin
                errors++;
                $display("row drive malformed at %0t ns: row is %b, not exactly one low bit",
                         $time, row);
            end
            else
            begin
                idx = 0;
                for (int i = 0; i < 8; i++)
                    if (!row[i])
                        idx = i;
                check_value(idx, (prev_idx + 1) % 8, "row scan order");
                prev_idx = idx;
                if (rows_left > 0 && (idx == 0 || rows_left < 8))
                begin
                    exp = expected_cols(exp_pattern, exp_mask, exp_blank, idx[2:0]);
                    check_value(colr, exp[7:0], $sformatf("colr on row %0d", idx));
                    check_value(colg, exp[15:8], $sformatf("colg on row %0d", idx));
                    rows_left--;
                end
            end
        end
    end

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #1;
        wr_en   = 1'b0;
    endtask

    task automatic apply_settings(input logic [2:0] p, input logic [1:0] m, input logic b);
        write_reg(REG_PATTERN, {5'b0, p});
        write_reg(REG_COLOR, {6'b0, m});
        write_reg(REG_BLANK, {7'b0, b});
        exp_pattern = p;
        exp_mask    = m;
        exp_blank   = b;
    endtask

    task automatic wait_rows(input int n);
        int target;
        target = rows_seen + n;
        wait (rows_seen >= target);
    endtask

    // compare one whole frame from row 0
    task automatic check_frame();
        rows_left = 8;
        wait (rows_left == 0);
    endtask

    task automatic settle_and_check();
        wait_rows(16);
        check_frame();
    endtask

    task automatic draw_bits(input int n, output logic [7:0] value);
        value = 8'h00;
        for (int i = 0; i < n; i++)
        begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%-22s %0d mismatches", name, errors - err_start);
    endtask

    initial
    begin
        int         err_start;
        logic [7:0] p;
        logic [7:0] m;
        logic [7:0] b;
        clk         = 1'b0;
        rst         = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = 2'd0;
        wr_data     = 8'h00;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        rows_seen   = 0;
        rows_left   = 0;
        prev_row    = 8'hFF;
        prev_idx    = 7;    // first row after reset must be 0
        exp_pattern = 3'd0;
        exp_mask    = 2'd0;
        exp_blank   = 1'b0;
        lfsr_state  = 32'he2f9_df9b;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset state and the dark frame
        err_start = errors;
        check_value(row, 8'hFF, "row after reset");
        check_value(colr, 8'h00, "colr after reset");
        check_value(colg, 8'h00, "colg after reset");
        rows_left = 8;
        while (row === 8'hFF)
        begin
            @(negedge clk);
            if (row === 8'hFF)
            begin
                check_value(colr, 8'h00, "colr before first tick");
                check_value(colg, 8'h00, "colg before first tick");
            end
        end
        wait (rows_left == 0);
        report_test("reset_and_dark", err_start);

        err_start = errors;
        for (int pat = 1; pat < 8; pat++)
        begin
            apply_settings(pat[2:0], 2'b11, 1'b0);
            settle_and_check();
        end
        report_test("all_patterns", err_start);

        err_start = errors;
        apply_settings(3'd4, 2'b01, 1'b0);
        settle_and_check();
        apply_settings(3'd4, 2'b10, 1'b0);
        settle_and_check();
        apply_settings(3'd4, 2'b00, 1'b0);
        settle_and_check();
        report_test("colour_mask", err_start);

        err_start = errors;
        apply_settings(3'd7, 2'b11, 1'b1);
        settle_and_check();
        apply_settings(3'd7, 2'b11, 1'b0);
        settle_and_check();
        report_test("blank", err_start);

        err_start = errors;
        apply_settings(3'd1, 2'b01, 1'b0);
        settle_and_check();
        write_reg(2'd3, 8'hFF);   // decodes to nothing
        settle_and_check();
        apply_settings(3'd5, 2'b11, 1'b0);
        wait_rows(16);
        rows_left = 8;
        wait (rows_left == 5);
        write_reg(REG_PATTERN, 8'h02);  // lands mid-frame
        wait (rows_left == 0);
        exp_pattern = 3'd2;
        check_frame();
        report_test("unused_addr_and_tear", err_start);

        err_start = errors;
        for (int round = 0; round < 12; round++)
        begin
            draw_bits(3, p);
            draw_bits(2, m);
            draw_bits(1, b);
            apply_settings(p[2:0], m[1:0], b[0]);
            settle_and_check();
        end
        report_test("random_settings", err_start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
+incdir+verification
design/dot_matrix_pkg.sv
design/reg_map_pkg.sv
design/scan_tick_gen.sv
design/matrix_config_regs.sv
design/glyph_rom.sv
design/matrix_row_scanner.sv
design/matrix_display_top.sv
verification/matrix_display_tb.sv
